/* project.f */
+incdir+rtl
rtl/decode_pkg.sv
rtl/decoded_if.sv
rtl/rv_decoder.sv
rtl/issue_stage.sv
rtl/scoreboard.sv
rtl/register_file.sv
rtl/alu_operand_gen.sv
rtl/decode_issue_top.sv
test/tb_clock_gen.sv
test/tb_decode_issue.sv

/* rtl/alu_operand_gen.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decode_defines.svh"

module alu_operand_gen (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_i,
    decoded_if.sink                   held,
    input  decode_pkg::word_t         rs1_data_i,
    input  decode_pkg::word_t         rs2_data_i,
    output logic                      alu_valid_o,
    output decode_pkg::alu_op_t       alu_op_o,
    output decode_pkg::alu_logic_op_t alu_logic_op_o,
    output logic                      alu_subtract_o,
    output decode_pkg::operand_t      alu_in1_o,
    output decode_pkg::operand_t      alu_in2_o,
    output logic                      alu_lshift_o,
    output logic                      alu_arith_o,
    output decode_pkg::shamt_t        alu_shift_amount_o,
    output decode_pkg::word_t         alu_constant_o,
    output decode_pkg::reg_addr_t     alu_rd_o,
    output logic                      alu_uses_rd_o
);
    import decode_pkg::*;

    fn3_t     fn3;
    word_t    imm_i;
    word_t    rs2_sel;
    word_t    constant;
    operand_t in1;
    operand_t in2;
    shamt_t   shift_amount;

    assign fn3   = held.instruction[14:12];
    assign imm_i = {{(`XLEN_BITS-12){held.instruction[31]}}, held.instruction[31:20]};

    ////////////////////////////////////////////////////////////
    // Adder and compare operands
    // fn3 bit 0 marks SLTU, which compares unsigned
    assign rs2_sel = held.rs2_from_reg ? rs2_data_i : imm_i;
    assign in1 = {rs1_data_i[`XLEN_BITS-1] & ~fn3[0], rs1_data_i};
    assign in2 = {rs2_sel[`XLEN_BITS-1] & ~fn3[0], rs2_sel};

    // Register shifts take the low bits of rs2, immediates the field
    assign shift_amount = held.rs2_from_reg ? rs2_data_i[4:0] : held.rs2;

    // LUI and AUIPC
    assign constant = (held.sel_pc ? held.pc : '0) + {held.instruction[31:12], 12'b0};

    ////////////////////////////////////////////////////////////
    // Output bundle
    always_ff @(posedge clk) begin
        if (rst)
            alu_valid_o <= 1'b0;
        else
            alu_valid_o <= issue_i;
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            alu_op_o           <= held.alu_op;
            alu_logic_op_o     <= held.logic_op;
            alu_subtract_o     <= held.subtract;
            alu_in1_o          <= in1;
            alu_in2_o          <= in2;
            alu_lshift_o       <= ~fn3[2];
            alu_arith_o        <= rs1_data_i[`XLEN_BITS-1] & held.instruction[30];
            alu_shift_amount_o <= shift_amount;
            alu_constant_o     <= constant;
            alu_rd_o           <= held.rd;
            alu_uses_rd_o      <= held.uses_rd;
        end
    end

endmodule

`default_nettype wire

/* rtl/decode_defines.svh */
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// Datapath and register file sizes, fixed by RV32I
`define XLEN_BITS      32
`define REG_ADDR_BITS  5
`define NUM_REGS       32

////////////////////////////////////////////////////////////
// Opcode groups, taken from instruction bits [6:2]
`define OPC_ARITH      5'b01100
`define OPC_ARITH_IMM  5'b00100
`define OPC_LUI        5'b01101
`define OPC_AUIPC      5'b00101

////////////////////////////////////////////////////////////
// fn3 field codes, instruction bits [14:12]
`define FN3_ADD_SUB    3'b000
`define FN3_SLL        3'b001
`define FN3_SLT        3'b010
`define FN3_SLTU       3'b011
`define FN3_XOR        3'b100
`define FN3_SRL_SRA    3'b101
`define FN3_OR         3'b110
`define FN3_AND        3'b111

`endif

/* rtl/decode_issue_top.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_issue_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      decode_valid_i,
    input  decode_pkg::instr_t        instr_i,
    input  decode_pkg::word_t         pc_i,
    input  logic                      flush_i,
    input  logic                      alu_ready_i,
    input  logic                      wb_valid_i,
    input  decode_pkg::reg_addr_t     wb_rd_i,
    input  decode_pkg::word_t         wb_data_i,
    output logic                      decode_advance_o,
    output logic                      illegal_o,
    output logic                      alu_valid_o,
    output decode_pkg::alu_op_t       alu_op_o,
    output decode_pkg::alu_logic_op_t alu_logic_op_o,
    output logic                      alu_subtract_o,
    output decode_pkg::operand_t      alu_in1_o,
    output decode_pkg::operand_t      alu_in2_o,
    output logic                      alu_lshift_o,
    output logic                      alu_arith_o,
    output decode_pkg::shamt_t        alu_shift_amount_o,
    output decode_pkg::word_t         alu_constant_o,
    output decode_pkg::reg_addr_t     alu_rd_o,
    output logic                      alu_uses_rd_o
);

    logic              issue;
    logic              rs1_busy;
    logic              rs2_busy;
    logic              rd_busy;
    decode_pkg::word_t rs1_data;
    decode_pkg::word_t rs2_data;

    // Decoded instruction, and the one held in the issue stage
    decoded_if dec_if ();
    decoded_if held_if ();

    rv_decoder u_rv_decoder (
        .instr_i (instr_i),
        .pc_i    (pc_i),
        .dec     (dec_if)
    );

    issue_stage u_issue_stage (
        .clk         (clk),
        .rst         (rst),
        .valid_i     (decode_valid_i),
        .dec         (dec_if),
        .held        (held_if),
        .flush_i     (flush_i),
        .alu_ready_i (alu_ready_i),
        .rs1_busy_i  (rs1_busy),
        .rs2_busy_i  (rs2_busy),
        .rd_busy_i   (rd_busy),
        .advance_o   (decode_advance_o),
        .issue_o     (issue),
        .illegal_o   (illegal_o)
    );

    scoreboard u_scoreboard (
        .clk        (clk),
        .rst        (rst),
        .rs1_i      (held_if.rs1),
        .rs2_i      (held_if.rs2),
        .rd_i       (held_if.rd),
        .set_i      (issue & held_if.uses_rd),
        .set_rd_i   (held_if.rd),
        .clr_i      (wb_valid_i),
        .clr_rd_i   (wb_rd_i),
        .rs1_busy_o (rs1_busy),
        .rs2_busy_o (rs2_busy),
        .rd_busy_o  (rd_busy)
    );

    register_file u_register_file (
        .clk        (clk),
        .rs1_i      (held_if.rs1),
        .rs2_i      (held_if.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb_valid_i),
        .wd_rd_i    (wb_rd_i),
        .wd_data_i  (wb_data_i)
    );

    alu_operand_gen u_alu_operand_gen (
        .clk                (clk),
        .rst                (rst),
        .issue_i            (issue),
        .held               (held_if),
        .rs1_data_i         (rs1_data),
        .rs2_data_i         (rs2_data),
        .alu_valid_o        (alu_valid_o),
        .alu_op_o           (alu_op_o),
        .alu_logic_op_o     (alu_logic_op_o),
        .alu_subtract_o     (alu_subtract_o),
        .alu_in1_o          (alu_in1_o),
        .alu_in2_o          (alu_in2_o),
        .alu_lshift_o       (alu_lshift_o),
        .alu_arith_o        (alu_arith_o),
        .alu_shift_amount_o (alu_shift_amount_o),
        .alu_constant_o     (alu_constant_o),
        .alu_rd_o           (alu_rd_o),
        .alu_uses_rd_o      (alu_uses_rd_o)
    );

endmodule

`default_nettype wire

/* rtl/decode_pkg.sv */
`default_nettype none

`include "decode_defines.svh"

package decode_pkg;

    // Raw instruction and data words
    typedef logic [`XLEN_BITS-1:0] instr_t;
    typedef logic [`XLEN_BITS-1:0] word_t;

    // Data word plus the extra sign bit for the SLT compare
    typedef logic [`XLEN_BITS:0] operand_t;

    typedef logic [`REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [2:0] fn3_t;
    typedef logic [4:0] opcode_group_t;
    typedef logic [4:0] shamt_t;

    ////////////////////////////////////////////////////////////
    // ALU selections
    typedef enum logic [1:0] {
        ALU_CONSTANT = 2'b00,
        ALU_ADD_SUB  = 2'b01,
        ALU_SLT      = 2'b10,
        ALU_SHIFT    = 2'b11
    } alu_op_t;

    typedef enum logic [1:0] {
        ALU_LOGIC_XOR = 2'b00,
        ALU_LOGIC_OR  = 2'b01,
        ALU_LOGIC_AND = 2'b10,
        ALU_LOGIC_ADD = 2'b11
    } alu_logic_op_t;

endpackage

`default_nettype wire

/* rtl/decoded_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface decoded_if;
    import decode_pkg::*;

    instr_t        instruction;
    word_t         pc;
    reg_addr_t     rs1;
    reg_addr_t     rs2;
    reg_addr_t     rd;
    logic          uses_rs1;
    logic          uses_rs2;
    logic          uses_rd;
    alu_op_t       alu_op;
    alu_logic_op_t logic_op;
    logic          subtract;
    logic          sel_pc;
    logic          rs2_from_reg;
    logic          illegal;

    // Decoder side
    modport src (
        output instruction, pc, rs1, rs2, rd, uses_rs1, uses_rs2, uses_rd,
        output alu_op, logic_op, subtract, sel_pc, rs2_from_reg, illegal
    );

    // Issue stage capture side
    modport stage_in (
        input instruction, pc, rs1, rs2, rd, uses_rs1, uses_rs2, uses_rd,
        input alu_op, logic_op, subtract, sel_pc, rs2_from_reg, illegal
    );

    // Held instruction, driven by the issue register
    modport stage_out (
        output instruction, pc, rs1, rs2, rd, uses_rs1, uses_rs2, uses_rd,
        output alu_op, logic_op, subtract, sel_pc, rs2_from_reg, illegal
    );

    modport sink (
        input instruction, pc, rs1, rs2, rd, uses_rs1, uses_rs2, uses_rd,
        input alu_op, logic_op, subtract, sel_pc, rs2_from_reg, illegal
    );

endinterface

`default_nettype wire

/* rtl/issue_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_stage (
    input  logic         clk,
    input  logic         rst,
    input  logic         valid_i,
    decoded_if.stage_in  dec,
    decoded_if.stage_out held,
    input  logic         flush_i,
    input  logic         alu_ready_i,
    input  logic         rs1_busy_i,
    input  logic         rs2_busy_i,
    input  logic         rd_busy_i,
    output logic         advance_o,
    output logic         issue_o,
    output logic         illegal_o
);

    logic stage_valid;
    logic operands_ready;
    logic active;
    logic stage_ready;

    ////////////////////////////////////////////////////////////
    // Issue decision
    // A busy register only matters for fields the instruction uses
    assign operands_ready = ~(held.uses_rs1 & rs1_busy_i)
                          & ~(held.uses_rs2 & rs2_busy_i)
                          & ~(held.uses_rd & rd_busy_i);

    assign active    = stage_valid & ~flush_i;
    assign illegal_o = active & held.illegal;
    assign issue_o   = active & ~held.illegal & operands_ready & alu_ready_i;

    // Free slot, or the current instruction leaves this cycle
    assign stage_ready = ~stage_valid | illegal_o | issue_o;
    assign advance_o   = valid_i & stage_ready;

    ////////////////////////////////////////////////////////////
    // Issue register
    always_ff @(posedge clk) begin
        if (rst || flush_i)
            stage_valid <= 1'b0;
        else if (stage_ready)
            stage_valid <= valid_i;
    end

    always_ff @(posedge clk) begin
        if (stage_ready) begin
            held.instruction  <= dec.instruction;
            held.pc           <= dec.pc;
            held.rs1          <= dec.rs1;
            held.rs2          <= dec.rs2;
            held.rd           <= dec.rd;
            held.uses_rs1     <= dec.uses_rs1;
            held.uses_rs2     <= dec.uses_rs2;
            held.uses_rd      <= dec.uses_rd;
            held.alu_op       <= dec.alu_op;
            held.logic_op     <= dec.logic_op;
            held.subtract     <= dec.subtract;
            held.sel_pc       <= dec.sel_pc;
            held.rs2_from_reg <= dec.rs2_from_reg;
            held.illegal      <= dec.illegal;
        end
    end

endmodule

`default_nettype wire

/* rtl/register_file.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decode_defines.svh"

module register_file (
    input  logic                  clk,
    input  decode_pkg::reg_addr_t rs1_i,
    input  decode_pkg::reg_addr_t rs2_i,
    output decode_pkg::word_t     rs1_data_o,
    output decode_pkg::word_t     rs2_data_o,
    input  logic                  we_i,
    input  decode_pkg::reg_addr_t wd_rd_i,
    input  decode_pkg::word_t     wd_data_i
);

    // Registers power up cleared
    decode_pkg::word_t regs [`NUM_REGS] = '{default: '0};

    always_ff @(posedge clk) begin
        if (we_i && (wd_rd_i != '0))
            regs[wd_rd_i] <= wd_data_i;
    end

    // Asynchronous reads, no write-through
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

/* rtl/rv_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decode_defines.svh"

module rv_decoder (
    input  decode_pkg::instr_t instr_i,
    input  decode_pkg::word_t  pc_i,
    decoded_if.src             dec
);
    import decode_pkg::*;

    opcode_group_t opc;
    fn3_t          fn3;
    logic          is_arith;
    logic          is_arith_imm;
    logic          is_lui;
    logic          is_auipc;
    logic          mul_div;
    logic          legal;

    ////////////////////////////////////////////////////////////
    // Field extraction
    assign opc = instr_i[6:2];
    assign fn3 = instr_i[14:12];

    assign dec.instruction = instr_i;
    assign dec.pc          = pc_i;
    assign dec.rs1         = instr_i[19:15];
    assign dec.rs2         = instr_i[24:20];
    assign dec.rd          = instr_i[11:7];

    assign is_arith     = (opc == `OPC_ARITH);
    assign is_arith_imm = (opc == `OPC_ARITH_IMM);
    assign is_lui       = (opc == `OPC_LUI);
    assign is_auipc     = (opc == `OPC_AUIPC);

    // M extension encodings share the ARITH opcode
    assign mul_div = is_arith & instr_i[25];
    assign legal   = (is_arith & ~mul_div) | is_arith_imm | is_lui | is_auipc;

    ////////////////////////////////////////////////////////////
    // Register usage
    assign dec.uses_rs1 = is_arith | is_arith_imm;
    assign dec.uses_rs2 = is_arith;
    assign dec.uses_rd  = legal;

    ////////////////////////////////////////////////////////////
    // ALU control
    always_comb begin
        if (is_lui || is_auipc)
            dec.alu_op = ALU_CONSTANT;
        else if (fn3 inside {`FN3_SLT, `FN3_SLTU})
            dec.alu_op = ALU_SLT;
        else if (fn3 inside {`FN3_SLL, `FN3_SRL_SRA})
            dec.alu_op = ALU_SHIFT;
        else
            dec.alu_op = ALU_ADD_SUB;
    end

    always_comb begin
        case (fn3)
            `FN3_XOR: dec.logic_op = ALU_LOGIC_XOR;
            `FN3_OR:  dec.logic_op = ALU_LOGIC_OR;
            `FN3_AND: dec.logic_op = ALU_LOGIC_AND;
            default:  dec.logic_op = ALU_LOGIC_ADD;
        endcase
    end

    // SLT compares by subtraction, SUB only exists as register form
    assign dec.subtract = (fn3 inside {`FN3_SLT, `FN3_SLTU})
                        | (is_arith & (fn3 == `FN3_ADD_SUB) & instr_i[30]);

    assign dec.sel_pc       = is_auipc;
    assign dec.rs2_from_reg = is_arith;
    assign dec.illegal      = ~legal;

endmodule

`default_nettype wire

/* rtl/scoreboard.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decode_defines.svh"

module scoreboard (
    input  logic                  clk,
    input  logic                  rst,
    input  decode_pkg::reg_addr_t rs1_i,
    input  decode_pkg::reg_addr_t rs2_i,
    input  decode_pkg::reg_addr_t rd_i,
    input  logic                  set_i,
    input  decode_pkg::reg_addr_t set_rd_i,
    input  logic                  clr_i,
    input  decode_pkg::reg_addr_t clr_rd_i,
    output logic                  rs1_busy_o,
    output logic                  rs2_busy_o,
    output logic                  rd_busy_o
);

    // One pending-write flag per architectural register
    logic [`NUM_REGS-1:0] busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (clr_i)
                busy[clr_rd_i] <= 1'b0;
            // x0 is never written, so it never waits
            if (set_i && (set_rd_i != '0))
                busy[set_rd_i] <= 1'b1;
        end
    end

    assign rs1_busy_o = busy[rs1_i];
    assign rs2_busy_o = busy[rs2_i];
    assign rd_busy_o  = busy[rd_i];

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the decode/issue testbench with Verilator

cd "$(dirname "$0")" || exit 1
mkdir -p build
if ! verilator --binary --timing -f project.f --top-module tb_decode_issue -Mdir build/obj; then
    echo "Verilator build failed"
    exit 1
fi
./build/obj/Vtb_decode_issue > build/sim.log 2>&1
sim_status=$?
cat build/sim.log
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
if grep -qx "Test OK" build/sim.log; then
    exit 0
fi
exit 1

/* test/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset held for two rising edges, released mid-cycle
    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

/* test/tb_decode_issue.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decode_defines.svh"

module tb_decode_issue;
    import decode_pkg::*;

    localparam int NUM_INSTR      = 250;
    localparam int TIMEOUT_CYCLES = 40 * NUM_INSTR;

    localparam logic [6:0] OP_ARITH     = 7'b0110011;
    localparam logic [6:0] OP_ARITH_IMM = 7'b0010011;
    localparam logic [6:0] OP_LUI       = 7'b0110111;
    localparam logic [6:0] OP_AUIPC     = 7'b0010111;

    typedef struct packed {
        alu_op_t       op;
        alu_logic_op_t logic_op;
        logic          subtract;
        operand_t      in1;
        operand_t      in2;
        logic          lshift;
        logic          arith;
        shamt_t        shamt;
        word_t         constant;
        reg_addr_t     rd;
        logic          uses_rd;
    } bundle_t;

    typedef struct packed {
        logic    illegal;
        bundle_t exp;
        word_t   result;
    } pending_t;

    typedef struct packed {
        reg_addr_t rd;
        word_t     data;
        int        due;
    } wb_t;

    logic          clk;
    logic          rst;
    logic          decode_valid_i;
    instr_t        instr_i;
    word_t         pc_i;
    logic          flush_i;
    logic          alu_ready_i;
    logic          wb_valid_i;
    reg_addr_t     wb_rd_i;
    word_t         wb_data_i;
    logic          decode_advance_o;
    logic          illegal_o;
    logic          alu_valid_o;
    alu_op_t       alu_op_o;
    alu_logic_op_t alu_logic_op_o;
    logic          alu_subtract_o;
    operand_t      alu_in1_o;
    operand_t      alu_in2_o;
    logic          alu_lshift_o;
    logic          alu_arith_o;
    shamt_t        alu_shift_amount_o;
    word_t         alu_constant_o;
    reg_addr_t     alu_rd_o;
    logic          alu_uses_rd_o;

    int       seed = 51;
    int       cycles = 0;
    string    test_name = "reset";
    // Register state in program order
    word_t    arch [`NUM_REGS] = '{default: '0};
    word_t    arch_saved [`NUM_REGS];
    pending_t expected [$];
    wb_t      wb_queue [$];
    logic     random_ready = 1'b0;
    logic     hold_ready = 1'b0;
    word_t    next_pc = 32'h0000_1000;

    tb_clock_gen u_tb_clock_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    decode_issue_top u_decode_issue_top (.*);

    ////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_operand(input string what, input operand_t exp, input operand_t act);
        if (exp !== act)
            stop_run($sformatf("CHECK FAILED %s %s: expected %h, actual %h",
                               test_name, what, exp, act));
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (exp !== act)
            stop_run($sformatf("CHECK FAILED %s %s: expected %h, actual %h",
                               test_name, what, exp, act));
    endtask

    task automatic check_op(input alu_op_t exp, input alu_op_t act);
        if (exp !== act)
            stop_run($sformatf("CHECK FAILED %s alu_op: expected %s, actual %s",
                               test_name, exp.name(), act.name()));
    endtask

    task automatic check_logic_op(input alu_logic_op_t exp, input alu_logic_op_t act);
        if (exp !== act)
            stop_run($sformatf("CHECK FAILED %s logic_op: expected %s, actual %s",
                               test_name, exp.name(), act.name()));
    endtask

    task automatic check_reg(input string what, input reg_addr_t exp, input reg_addr_t act);
        if (exp !== act)
            stop_run($sformatf("CHECK FAILED %s %s: expected %0d, actual %0d",
                               test_name, what, exp, act));
    endtask

    task automatic check_shamt(input shamt_t exp, input shamt_t act);
        if (exp !== act)
            stop_run($sformatf("CHECK FAILED %s shift_amount: expected %0d, actual %0d",
                               test_name, exp, act));
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act)
            stop_run($sformatf("CHECK FAILED %s %s: expected %b, actual %b",
                               test_name, what, exp, act));
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    function automatic bundle_t expected_bundle(input instr_t ins, input word_t pc,
                                                input word_t regs [`NUM_REGS]);
        bundle_t e;
        fn3_t    f3;
        logic    is_op;
        logic    is_upper;
        word_t   a;
        word_t   b;
        f3       = ins[14:12];
        is_op    = (ins[6:0] == OP_ARITH);
        is_upper = (ins[6:0] == OP_LUI) || (ins[6:0] == OP_AUIPC);
        a        = regs[ins[19:15]];
        b        = is_op ? regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
        if (is_upper)
            e.op = ALU_CONSTANT;
        else if (f3 == 3'b010 || f3 == 3'b011)
            e.op = ALU_SLT;
        else if (f3 == 3'b001 || f3 == 3'b101)
            e.op = ALU_SHIFT;
        else
            e.op = ALU_ADD_SUB;
        case (f3)
            3'b100:  e.logic_op = ALU_LOGIC_XOR;
            3'b110:  e.logic_op = ALU_LOGIC_OR;
            3'b111:  e.logic_op = ALU_LOGIC_AND;
            default: e.logic_op = ALU_LOGIC_ADD;
        endcase
        e.subtract = (f3 == 3'b010) || (f3 == 3'b011) || (is_op && f3 == 3'b000 && ins[30]);
        // Unsigned compare drops the sign extension
        e.in1      = {a[31] & ~f3[0], a};
        e.in2      = {b[31] & ~f3[0], b};
        e.lshift   = ~f3[2];
        e.arith    = a[31] & ins[30];
        e.shamt    = is_op ? b[4:0] : ins[24:20];
        e.constant = ((ins[6:0] == OP_AUIPC) ? pc : 32'h0) + {ins[31:12], 12'h000};
        e.rd       = ins[11:7];
        e.uses_rd  = 1'b1;
        return e;
    endfunction

    // Result the ALU would write back
    function automatic word_t alu_result(input instr_t ins, input word_t pc,
                                         input word_t regs [`NUM_REGS]);
        word_t  a;
        word_t  b;
        shamt_t sh;
        logic   is_op;
        is_op = (ins[6:0] == OP_ARITH);
        a     = regs[ins[19:15]];
        b     = is_op ? regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
        sh    = b[4:0];
        if (ins[6:0] == OP_LUI)
            return {ins[31:12], 12'h000};
        if (ins[6:0] == OP_AUIPC)
            return pc + {ins[31:12], 12'h000};
        case (ins[14:12])
            3'b000:  return (is_op && ins[30]) ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return ins[30] ? word_t'($signed(a) >>> sh) : a >> sh;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Instruction encoding
    function automatic instr_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input fn3_t f3, input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP_ARITH};
    endfunction

    function automatic instr_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                     input fn3_t f3, input reg_addr_t rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instr_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                     input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    // Registers x0..x7 only, so dependencies are frequent
    function automatic instr_t rand_legal();
        int          r;
        int          r2;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        fn3_t        f3;
        logic [11:0] imm;
        r   = $random(seed);
        r2  = $random(seed);
        rd  = {2'b0, r[6:4]};
        f3  = r[9:7];
        rs1 = {2'b0, r[12:10]};
        rs2 = {2'b0, r[15:13]};
        imm = r2[11:0];
        if (f3 == 3'b001)
            imm = {7'h00, r2[4:0]};
        else if (f3 == 3'b101)
            imm = {r[16] ? 7'h20 : 7'h00, r2[4:0]};
        if (r[3:0] == 4'd0)
            return enc_u(r2[19:0], rd, OP_LUI);
        else if (r[3:0] == 4'd1)
            return enc_u(r2[19:0], rd, OP_AUIPC);
        else if (r[3:0] < 4'd9)
            return enc_r(((f3 == 3'b000 || f3 == 3'b101) && r[16]) ? 7'h20 : 7'h00,
                         rs2, rs1, f3, rd);
        else
            return enc_i(imm, rs1, f3, rd, OP_ARITH_IMM);
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus helpers, entered on a falling edge
    task automatic send(input instr_t ins, input logic is_illegal);
        pending_t item;
        logic     taken;
        decode_valid_i = 1'b1;
        instr_i        = ins;
        pc_i           = next_pc;
        taken          = 1'b0;
        while (!taken) begin
            #1;
            taken = decode_advance_o;
            if (taken) begin
                item.illegal = is_illegal;
                item.exp     = expected_bundle(ins, next_pc, arch);
                item.result  = alu_result(ins, next_pc, arch);
                expected.push_back(item);
                if (!is_illegal && ins[11:7] != 5'd0)
                    arch[ins[11:7]] = item.result;
            end
            @(negedge clk);
        end
        decode_valid_i = 1'b0;
        next_pc        = next_pc + 32'd4;
    endtask

    task automatic wait_idle();
        while (expected.size() != 0 || wb_queue.size() != 0)
            @(negedge clk);
    endtask

    // ALU back-pressure
    always @(negedge clk) begin : drive_ready
        int r;
        r = $random(seed);
        if (hold_ready)
            alu_ready_i = 1'b0;
        else
            alu_ready_i = random_ready ? (r[1:0] != 2'b00) : 1'b1;
    end

    // Writeback responder
    always @(negedge clk) begin
        wb_valid_i = 1'b0;
        if (wb_queue.size() != 0 && cycles >= wb_queue[0].due) begin
            wb_valid_i = 1'b1;
            wb_rd_i    = wb_queue[0].rd;
            wb_data_i  = wb_queue[0].data;
            void'(wb_queue.pop_front());
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
            stop_run($sformatf("Timeout after %0d cycles in test %s", cycles, test_name));
    end

    ////////////////////////////////////////////////////////////
    // Output comparison, sampled mid-cycle
    always @(negedge clk) begin : compare_outputs
        pending_t item;
        bundle_t  e;
        wb_t      wb;
        int       r;
        #2;
        if (!rst && alu_valid_o) begin
            if (expected.size() == 0) begin
                stop_run("ALU bundle appeared with no instruction pending");
            end else begin
                item = expected.pop_front();
                if (item.illegal) begin
                    stop_run("An illegal instruction produced an ALU bundle");
                end else begin
                    e = item.exp;
                    check_op(e.op, alu_op_o);
                    check_logic_op(e.logic_op, alu_logic_op_o);
                    check_bit("subtract", e.subtract, alu_subtract_o);
                    check_reg("rd", e.rd, alu_rd_o);
                    check_bit("uses_rd", e.uses_rd, alu_uses_rd_o);
                    if (e.op == ALU_CONSTANT) begin
                        check_word("constant", e.constant, alu_constant_o);
                    end else begin
                        check_operand("in1", e.in1, alu_in1_o);
                        check_operand("in2", e.in2, alu_in2_o);
                        check_bit("lshift", e.lshift, alu_lshift_o);
                        check_bit("arith", e.arith, alu_arith_o);
                        check_shamt(e.shamt, alu_shift_amount_o);
                    end
                    if (e.rd != 5'd0) begin
                        r       = $random(seed);
                        wb.rd   = e.rd;
                        wb.data = item.result;
                        wb.due  = cycles + 1 + (r & 3);
                        wb_queue.push_back(wb);
                    end
                end
            end
        end
        if (!rst && illegal_o) begin
            if (expected.size() == 0 || !expected[0].illegal)
                stop_run("illegal_o pulsed for a legal instruction");
            else
                void'(expected.pop_front());
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    initial begin
        decode_valid_i = 1'b0;
        instr_i        = '0;
        pc_i           = '0;
        flush_i        = 1'b0;
        alu_ready_i    = 1'b1;
        wb_valid_i     = 1'b0;
        wb_rd_i        = '0;
        wb_data_i      = '0;
        @(negedge rst);

        test_name = "upper_imm";
        for (int i = 1; i < 8; i++) begin
            send(enc_u(20'h8a5c3 + 20'(i * 4099), reg_addr_t'(i), OP_LUI), 1'b0);
            send(enc_i(12'h7f1 - 12'(i * 97), reg_addr_t'(i), 3'b000, reg_addr_t'(i),
                       OP_ARITH_IMM), 1'b0);
        end
        send(enc_u(20'h12345, 5'd6, OP_AUIPC), 1'b0);
        send(enc_u(20'hfffff, 5'd7, OP_AUIPC), 1'b0);

        test_name = "alu_ops";
        for (int f = 0; f < 8; f++)
            send(enc_r(7'h00, reg_addr_t'(7 - f % 7), reg_addr_t'(1 + f % 7), fn3_t'(f),
                       reg_addr_t'(1 + (f + 3) % 7)), 1'b0);
        send(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), 1'b0);
        send(enc_r(7'h20, 5'd2, 5'd7, 3'b101, 5'd4), 1'b0);
        for (int f = 0; f < 8; f++)
            send(enc_i((f == 1) ? 12'h003 : (f == 5) ? 12'h405 : 12'h8f3,
                       reg_addr_t'(1 + f % 7), fn3_t'(f), reg_addr_t'(1 + (f + 2) % 7),
                       OP_ARITH_IMM), 1'b0);
        send(enc_i(12'h007, 5'd5, 3'b101, 5'd2, OP_ARITH_IMM), 1'b0);

        test_name    = "random_stream";
        random_ready = 1'b1;
        repeat (200) send(rand_legal(), 1'b0);

        // JAL, JALR, load, store, branch, system and a multiply
        test_name = "illegal";
        send(enc_i(12'h123, 5'd1, 3'b000, 5'd2, 7'b1101111), 1'b1);
        send(enc_i(12'h123, 5'd1, 3'b000, 5'd2, 7'b1100111), 1'b1);
        send(enc_i(12'h010, 5'd1, 3'b010, 5'd2, 7'b0000011), 1'b1);
        send(enc_i(12'h010, 5'd1, 3'b010, 5'd2, 7'b0100011), 1'b1);
        send(enc_i(12'h010, 5'd1, 3'b000, 5'd2, 7'b1100011), 1'b1);
        send(enc_i(12'h000, 5'd0, 3'b000, 5'd0, 7'b1110011), 1'b1);
        send(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd3), 1'b1);
        send(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b0);
        wait_idle();

        // Held instruction dropped by a flush
        test_name  = "flush";
        hold_ready = 1'b1;
        arch_saved = arch;
        send(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd5), 1'b0);
        flush_i = 1'b1;
        void'(expected.pop_back());
        arch = arch_saved;
        @(negedge clk);
        flush_i    = 1'b0;
        hold_ready = 1'b0;
        send(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd5), 1'b0);
        send(enc_r(7'h00, 5'd5, 5'd5, 3'b000, 5'd6), 1'b0);
        send(enc_i(12'h00f, 5'd6, 3'b111, 5'd5, OP_ARITH_IMM), 1'b0);
        wait_idle();

        if (expected.size() == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            stop_run("Instructions still pending at the end of the run");
        end
    end

endmodule

`default_nettype wire
